/* dv/cart_checker.sv */
`timescale 1ns/10ps
`include "cart_cfg.svh"

module cart_checker
  import cart_bus_pkg::*;
  import cart_mem_pkg::*;
(
  input  logic        CLK,
  input  logic        reset,
  input  logic        req_valid,
  input  logic        req_ready,
  input  bus_op_e     req_op,
  input  logic        req_pa_cycle,
  input  logic [23:0] req_addr,
  input  logic [7:0]  req_pa,
  input  logic        req_cs,
  input  logic [7:0]  req_wdata,
  input  logic [7:0]  featurebits,
  input  logic [23:0] rom_mask,
  input  logic        rsp_valid,
  input  logic [7:0]  rsp_data,
  input  target_e     rsp_target,
  input  logic        sram_oe,
  input  logic [23:0] sram_addr,
  output int          err_count,
  output int          rsp_count
);

  logic [7:0]  cmd_buf [16];   // Shadow snescmd buffer
  logic [7:0]  latch_q;        // Shadow PA 3f latch
  target_e     exp_tgt [$];
  logic [7:0]  exp_data [$];
  int          exp_acc [$];    // Cycle of the accept edge
  int          exp_lat [$];    // Edges from accept to sampled rsp_valid
  seq_state_e  model_st;       // Expected sequencer state, for messages
  int          cyc;
  logic        rst_q;          // First cycle out of reset
  target_e     tgt;
  logic [7:0]  data;
  logic [23:0] ra;             // Expected SRAM address of the last ROM read
  int          lat;
  int          acc;

  ////////////////////////////////////////
  // Reference model of the bus rules
  ////////////////////////////////////////
  // LoROM puts bank bits 22:16 right above the 15-bit offset
  function automatic logic [23:0] fold(input logic [23:0] a);
    return ((a & 24'h7f0000) >> 1) | (a & 24'h007fff);
  endfunction

  function automatic target_e decode(input logic pc, input logic [23:0] a,
                                     input logic [7:0] pa, input logic cs,
                                     input logic [7:0] fb);
    logic [15:0] off;
    off = a[15:0];
    if (pc) begin
      if (pa >= 8'hf0) return TGT_CMD_RD;
      if (pa == 8'h3f && fb[`CART_FEAT_213F]) return TGT_213F;
      return TGT_NONE;
    end
    if (a[23:4] == `CART_SNESCMD_WR_BASE) return TGT_CMD_WR;
    if (!a[22] && off >= 16'h2000 && off <= 16'h2007 && fb[`CART_FEAT_MSU1])
      return TGT_MSU;
    if (!a[22] && off >= 16'h6000 && off <= 16'h7fff) return TGT_CX4;
    if (cs) return TGT_ROM;                // ROM select is the last resort
    return TGT_NONE;
  endfunction

  ////////////////////////////////////////
  // Watch and compare
  ////////////////////////////////////////
  always @(posedge CLK) begin
    if (reset) begin
      for (int i = 0; i < 16; i++) cmd_buf[i] = 8'h00;
      latch_q = 8'h00;
      exp_tgt.delete();
      exp_data.delete();
      exp_acc.delete();
      exp_lat.delete();
      model_st  = S_IDLE;
      cyc       = 0;
      err_count = 0;
      rsp_count = 0;
      rst_q     = 1'b1;
    end else begin
      cyc++;
      if (rst_q) begin                     // Idle outputs out of reset
        if (rsp_valid !== 1'b0) begin
          err_count++;
          $display("ERR %0t rsp_valid exp 0 got %b", $time, rsp_valid);
        end
        if (sram_oe !== 1'b0) begin
          err_count++;
          $display("ERR %0t sram_oe exp 0 got %b", $time, sram_oe);
        end
        if (req_ready !== 1'b1) begin
          err_count++;
          $display("ERR %0t req_ready exp 1 got %b", $time, req_ready);
        end
        rst_q = 1'b0;
      end
      // Folded and masked address while the SRAM is enabled
      if (sram_oe === 1'b1 && sram_addr !== ra) begin
        err_count++;
        $display("ERR %0t sram_addr exp %06h got %06h", $time, ra, sram_addr);
      end
      // Response first since both can share one edge
      if (rsp_valid === 1'b1) begin
        rsp_count++;
        if (exp_tgt.size() == 0) begin
          err_count++;
          $display("Response at %0t arrived with no request pending", $time);
        end else begin
          tgt  = exp_tgt.pop_front();
          data = exp_data.pop_front();
          acc  = exp_acc.pop_front();
          lat  = exp_lat.pop_front();
          if (rsp_target !== tgt) begin
            err_count++;
            $display("ERR %0t rsp_target exp %s got %s", $time, tgt.name(),
                     rsp_target.name());
          end
          if (rsp_data !== data) begin
            err_count++;
            $display("ERR %0t rsp_data exp %02h got %02h", $time, data, rsp_data);
          end
          if (cyc - acc != lat) begin
            err_count++;
            $display("ERR %0t rsp_latency exp %0d got %0d", $time, lat, cyc - acc);
          end
          model_st = S_IDLE;
        end
      end
      if (req_valid === 1'b1 && req_ready === 1'b1) begin
        if (exp_tgt.size() != 0) begin
          err_count++;
          $display("Request accepted at %0t while the sequencer should be in %s",
                   $time, model_st.name());
        end
        tgt  = decode(req_pa_cycle, req_addr, req_pa, req_cs, featurebits);
        data = 8'h00;                      // Writes and misses answer zero
        lat  = 2;
        case (tgt)
          TGT_ROM: if (req_op == OP_READ) begin
            ra   = fold(req_addr) & rom_mask;
            data = ra[7:0] ^ ra[15:8];     // SRAM model byte
            lat  = `CART_ROM_LATENCY + 2;
          end
          TGT_MSU, TGT_CX4: if (req_op == OP_READ) data = `CART_OPEN_BUS;
          TGT_CMD_WR: if (req_op == OP_WRITE) cmd_buf[req_addr[3:0]] = req_wdata;
          TGT_CMD_RD: if (req_op == OP_READ) data = cmd_buf[req_pa[3:0]];
          TGT_213F: begin
            if (req_op == OP_WRITE) latch_q = req_wdata;
            else data = latch_q;
          end
          default: ;
        endcase
        model_st = (lat > 2) ? S_ROM_WAIT : S_RESP;
        exp_tgt.push_back(tgt);
        exp_data.push_back(data);
        exp_acc.push_back(cyc);
        exp_lat.push_back(lat);
      end
    end
  end

endmodule

/* dv/cart_tb.sv */
`timescale 1ns/10ps
`include "cart_cfg.svh"

module cart_tb
  import cart_bus_pkg::*;
();

  localparam logic [7:0]  FB_ON    = 8'h18;      // MSU and 213f decode
  localparam logic [7:0]  FB_OFF   = 8'h00;
  localparam logic [23:0] M_FULL   = 24'hffffff;
  localparam logic [23:0] M_NARROW = 24'h03ffff; // 256 KiB ROM

  logic        CLK;
  logic        reset;
  logic        req_valid;
  logic        req_ready;
  bus_op_e     req_op;
  logic        req_pa_cycle;
  logic [23:0] req_addr;
  logic [7:0]  req_pa;
  logic        req_cs;
  logic [7:0]  req_wdata;
  logic [7:0]  featurebits;
  logic [23:0] rom_mask;
  logic        rsp_valid;
  logic [7:0]  rsp_data;
  target_e     rsp_target;
  logic        sram_oe;
  logic [23:0] sram_addr;
  logic [7:0]  sram_rdata;
  int          chk_errors;
  int          rsp_count;
  int          tb_errors;
  int          n_req;
  logic [31:0] rng;

  // Request table with one entry per index
  bus_op_e     t_op [$];
  logic        t_pc [$];
  logic        t_cs [$];
  logic [23:0] t_addr [$];
  logic [7:0]  t_pa [$];
  logic [7:0]  t_wd [$];
  logic [7:0]  t_fb [$];
  logic [23:0] t_mask [$];

  always #20 CLK = ~CLK;                         // 40 ns period

  // SRAM model returns a byte made from the address
  assign sram_rdata = sram_oe ? (sram_addr[7:0] ^ sram_addr[15:8]) : 8'h00;

  cart_top u_dut (
    .CLK (CLK), .reset (reset),
    .req_valid (req_valid), .req_ready (req_ready), .req_op (req_op),
    .req_pa_cycle (req_pa_cycle), .req_addr (req_addr), .req_pa (req_pa),
    .req_cs (req_cs), .req_wdata (req_wdata),
    .featurebits (featurebits), .rom_mask (rom_mask),
    .rsp_valid (rsp_valid), .rsp_data (rsp_data), .rsp_target (rsp_target),
    .sram_oe (sram_oe), .sram_addr (sram_addr), .sram_rdata (sram_rdata)
  );

  cart_checker u_chk (
    .CLK (CLK), .reset (reset),
    .req_valid (req_valid), .req_ready (req_ready), .req_op (req_op),
    .req_pa_cycle (req_pa_cycle), .req_addr (req_addr), .req_pa (req_pa),
    .req_cs (req_cs), .req_wdata (req_wdata),
    .featurebits (featurebits), .rom_mask (rom_mask),
    .rsp_valid (rsp_valid), .rsp_data (rsp_data), .rsp_target (rsp_target),
    .sram_oe (sram_oe), .sram_addr (sram_addr),
    .err_count (chk_errors), .rsp_count (rsp_count)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic add_req(input bus_op_e op, input logic pc, input logic cs,
                         input logic [23:0] addr, input logic [7:0] pa,
                         input logic [7:0] wd, input logic [7:0] fb,
                         input logic [23:0] mask);
    t_op.push_back(op);
    t_pc.push_back(pc);
    t_cs.push_back(cs);
    t_addr.push_back(addr);
    t_pa.push_back(pa);
    t_wd.push_back(wd);
    t_fb.push_back(fb);
    t_mask.push_back(mask);
  endtask

  ////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////
  task automatic build_table();
    // ROM across banks with bit 15 both ways and a narrowed mask
    add_req(OP_READ,  1'b0, 1'b1, 24'h008123, 8'h00, 8'h00, FB_ON,  M_FULL);
    add_req(OP_READ,  1'b0, 1'b1, 24'h81fedc, 8'h00, 8'h00, FB_ON,  M_FULL);
    add_req(OP_READ,  1'b0, 1'b1, 24'h451234, 8'h00, 8'h00, FB_ON,  M_FULL);
    add_req(OP_READ,  1'b0, 1'b1, 24'h3fb1c2, 8'h00, 8'h00, FB_ON,  M_NARROW);
    add_req(OP_READ,  1'b0, 1'b1, 24'h7dc567, 8'h00, 8'h00, FB_ON,  M_NARROW);
    add_req(OP_WRITE, 1'b0, 1'b1, 24'h009000, 8'h00, 8'h99, FB_ON,  M_FULL);
    // snescmd fill with one write that also has ROM select high
    add_req(OP_WRITE, 1'b0, 1'b0, 24'hccccc0, 8'h00, 8'h5a, FB_ON,  M_FULL);
    add_req(OP_WRITE, 1'b0, 1'b1, 24'hccccc5, 8'h00, 8'ha5, FB_ON,  M_FULL);
    add_req(OP_WRITE, 1'b0, 1'b0, 24'hcccccf, 8'h00, 8'h3c, FB_ON,  M_FULL);
    add_req(OP_READ,  1'b1, 1'b0, 24'h000000, 8'hf0, 8'h00, FB_ON,  M_FULL);
    add_req(OP_READ,  1'b1, 1'b0, 24'h000000, 8'hf5, 8'h00, FB_ON,  M_FULL);
    add_req(OP_READ,  1'b1, 1'b0, 24'h000000, 8'hff, 8'h00, FB_ON,  M_FULL);
    add_req(OP_READ,  1'b1, 1'b0, 24'h000000, 8'hf1, 8'h00, FB_OFF, M_FULL);
    // MSU window gated by bank bit 22 and the feature bit
    add_req(OP_READ,  1'b0, 1'b1, 24'h002003, 8'h00, 8'h00, FB_ON,  M_FULL);
    add_req(OP_WRITE, 1'b0, 1'b0, 24'h802007, 8'h00, 8'h42, FB_ON,  M_FULL);
    add_req(OP_READ,  1'b0, 1'b1, 24'h402001, 8'h00, 8'h00, FB_ON,  M_FULL);
    add_req(OP_READ,  1'b0, 1'b1, 24'h002004, 8'h00, 8'h00, FB_OFF, M_FULL);
    add_req(OP_READ,  1'b0, 1'b0, 24'h002002, 8'h00, 8'h00, FB_OFF, M_FULL);
    // Cx4 MMIO
    add_req(OP_READ,  1'b0, 1'b1, 24'h007f40, 8'h00, 8'h00, FB_ON,  M_FULL);
    add_req(OP_READ,  1'b0, 1'b1, 24'hc06000, 8'h00, 8'h00, FB_ON,  M_FULL);
    add_req(OP_WRITE, 1'b0, 1'b0, 24'h006000, 8'h00, 8'h11, FB_ON,  M_FULL);
    // PA 3f latch with the feature on then off
    add_req(OP_WRITE, 1'b1, 1'b0, 24'h000000, 8'h3f, 8'h77, FB_ON,  M_FULL);
    add_req(OP_READ,  1'b1, 1'b0, 24'h000000, 8'h3f, 8'h00, FB_ON,  M_FULL);
    add_req(OP_READ,  1'b1, 1'b0, 24'h000000, 8'h3f, 8'h00, FB_OFF, M_FULL);
    n_req = t_op.size();
  endtask

  initial begin
    CLK = 1'b0;
    reset = 1'b1;
    req_valid = 1'b0;
    req_op = OP_READ;
    req_pa_cycle = 1'b0;
    req_addr = '0;
    req_pa = '0;
    req_cs = 1'b0;
    req_wdata = '0;
    featurebits = FB_OFF;
    rom_mask = M_FULL;
    rng = 32'h22a5;
    tb_errors = 0;
    build_table();
    repeat (5) @(negedge CLK);
    reset = 1'b0;
    for (int i = 0; i < n_req; i++) begin
      rng = xorshift(rng);
      repeat (rng[1:0]) @(negedge CLK);          // Idle gap of 0..3
      req_op       = t_op[i];
      req_pa_cycle = t_pc[i];
      req_cs       = t_cs[i];
      req_addr     = t_addr[i];
      req_pa       = t_pa[i];
      req_wdata    = t_wd[i];
      featurebits  = t_fb[i];
      rom_mask     = t_mask[i];
      req_valid    = 1'b1;
      while (!req_ready) @(negedge CLK);         // Hold while busy
      @(negedge CLK);                            // Taken on the edge just passed
      req_valid = 1'b0;
    end
    while (rsp_count < n_req) @(negedge CLK);
    repeat (6) @(negedge CLK);                   // Room for a stray response
    if (rsp_count != n_req) begin
      tb_errors++;
      $display("Saw %0d responses for %0d requests", rsp_count, n_req);
    end
    $display("Errors: %0d  Responses: %0d", chk_errors + tb_errors, rsp_count);
    if (chk_errors + tb_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  ////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////
  initial begin
    @(negedge reset);                            // Budget starts after reset
    #(n_req * (`CART_ROM_LATENCY + 8) * 40);
    $display("Watchdog expired after %0d of %0d responses", rsp_count, n_req);
    $display("Test failed");
    $finish;
  end

endmodule

/* hw/address.sv */
`timescale 1ns/10ps
`include "cart_cfg.svh"

module address
  import cart_bus_pkg::*;
(
  input  logic        req_pa_cycle,   // Peripheral bus access
  input  logic [23:0] req_addr,       // Main bus address
  input  logic [7:0]  req_pa,         // Peripheral address
  input  logic        req_cs,         // ROM select, active high
  input  logic [7:0]  featurebits,
  input  logic [23:0] rom_mask,
  output target_e     target,
  output logic [23:0] rom_addr,       // Folded and masked SRAM address
  output logic [3:0]  cmd_index       // snescmd buffer entry
);

  ////////////////////////////////////////
  // Window hits
  ////////////////////////////////////////
  logic msu_hit;
  logic cx4_hit;
  logic r213f_hit;
  logic cmd_rd_hit;
  logic cmd_wr_hit;

  // Banks 00-3f and 80-bf only
  assign msu_hit = featurebits[`CART_FEAT_MSU1] & ~req_addr[22]
                 & (req_addr[15:3] == 13'h0400);        // 2000..2007
  assign cx4_hit = ~req_addr[22] & (req_addr[15:13] == 3'b011);   // 6000..7fff

  assign r213f_hit  = featurebits[`CART_FEAT_213F] & (req_pa == 8'h3f);
  assign cmd_rd_hit = (req_pa[7:4] == 4'hf);            // PA f0..ff
  assign cmd_wr_hit = (req_addr[23:4] == `CART_SNESCMD_WR_BASE);

  ////////////////////////////////////////
  // Priority decode
  ////////////////////////////////////////
  always_comb begin
    target = TGT_NONE;
    if (req_pa_cycle) begin
      if (cmd_rd_hit)
        target = TGT_CMD_RD;
      else if (r213f_hit)
        target = TGT_213F;
    end else begin
      if (cmd_wr_hit)
        target = TGT_CMD_WR;     // Wins over ROM select
      else if (msu_hit)
        target = TGT_MSU;
      else if (cx4_hit)
        target = TGT_CX4;
      else if (req_cs)
        target = TGT_ROM;
    end
  end

  // LoROM fold
  // Bit 23 mirrors the bank and bit 15 only selects the upper half
  assign rom_addr = {2'b00, req_addr[22:16], req_addr[14:0]} & rom_mask;

  // Write window uses the address nibble, read window the PA nibble
  assign cmd_index = req_pa_cycle ? req_pa[3:0] : req_addr[3:0];

endmodule

/* hw/cart_bus_pkg.sv */
package cart_bus_pkg;

  ////////////////////////////////////////
  // Decode result of one host access
  ////////////////////////////////////////
  typedef enum logic [2:0] {
    TGT_NONE   = 3'd0,   // Not ours
    TGT_ROM    = 3'd1,   // LoROM through SRAM
    TGT_MSU    = 3'd2,   // MSU regs 2000..2007
    TGT_CX4    = 3'd3,   // Cx4 MMIO 6000..7fff
    TGT_213F   = 3'd4,   // PA 3f latch
    TGT_CMD_RD = 3'd5,   // snescmd buffer via PA f0..ff
    TGT_CMD_WR = 3'd6    // snescmd buffer via cccccx
  } target_e;

  // Direction of the host access
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } bus_op_e;

endpackage

/* hw/cart_cfg.svh */
`ifndef CART_CFG_SVH
`define CART_CFG_SVH

////////////////////////////////////////
// Feature bits
////////////////////////////////////////
`define CART_FEAT_MSU1 3        // Enables MSU register decode
`define CART_FEAT_213F 4        // Enables PA 3f latch decode

////////////////////////////////////////
// Windows and SRAM timing
////////////////////////////////////////
// Upper 20 address bits of the snescmd write window ccccc0..cccccf
`define CART_SNESCMD_WR_BASE 20'hccccc

`define CART_ROM_LATENCY 3      // SRAM read cycles
`define CART_LAT_CNT_W   2      // Enough for 0 .. latency-1

`define CART_OPEN_BUS 8'hff     // Claimed but unanswered MMIO reads

`endif

/* hw/cart_mem_pkg.sv */
package cart_mem_pkg;

  ////////////////////////////////////////
  // Request sequencer states
  ////////////////////////////////////////
  // Only ROM reads pass through S_ROM_WAIT
  typedef enum logic [1:0] {
    S_IDLE     = 2'd0,   // Ready for a request
    S_ROM_WAIT = 2'd1,   // SRAM output enable held
    S_RESP     = 2'd2    // Response goes out next cycle
  } seq_state_e;

endpackage

/* hw/cart_seq.sv */
`timescale 1ns/10ps
`include "cart_cfg.svh"

module cart_seq
  import cart_bus_pkg::*;
  import cart_mem_pkg::*;
(
  input  logic        CLK,
  input  logic        reset,
  input  logic        req_valid,
  input  bus_op_e     req_op,
  input  target_e     target,       // Live decode of the held request
  input  logic [23:0] rom_addr,
  input  logic [7:0]  sram_rdata,
  input  logic [7:0]  reg_rdata,
  output logic        req_ready,
  output logic        sram_oe,
  output logic [23:0] sram_addr,
  output logic        reg_wr_en,
  output logic        rsp_valid,
  output logic [7:0]  rsp_data,
  output target_e     rsp_target
);

  seq_state_e                 state;
  logic [`CART_LAT_CNT_W-1:0] lat_cnt;
  logic                       lat_last;
  logic                       accept;
  logic                       rom_rd;
  target_e                    tgt_q;
  bus_op_e                    op_q;
  logic [7:0]                 data_q;     // Response byte
  logic [7:0]                 acc_data;   // Byte known at accept time

  assign req_ready = (state == S_IDLE);   // One access in flight
  assign accept    = req_valid & req_ready;
  assign rom_rd    = (target == TGT_ROM) & (req_op == OP_READ);
  assign lat_last  = (lat_cnt == `CART_LAT_CNT_W'(`CART_ROM_LATENCY - 1));

  // Only the buffer window and the latch take writes
  assign reg_wr_en = accept & (req_op == OP_WRITE)
                   & ((target == TGT_CMD_WR) | (target == TGT_213F));

  ////////////////////////////////////////
  // Response data rule
  ////////////////////////////////////////
  always_comb begin
    case (target)
      TGT_MSU, TGT_CX4:     acc_data = (req_op == OP_READ) ? `CART_OPEN_BUS : 8'h00;
      TGT_CMD_RD, TGT_213F: acc_data = (req_op == OP_READ) ? reg_rdata : 8'h00;
      default:              acc_data = 8'h00;   // ROM read replaced later
    endcase
  end

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////
  always_ff @(posedge CLK) begin
    if (reset) begin
      state     <= S_IDLE;
      lat_cnt   <= '0;
      sram_oe   <= 1'b0;
      rsp_valid <= 1'b0;
      tgt_q     <= TGT_NONE;
      op_q      <= OP_READ;
    end else begin
      rsp_valid <= 1'b0;                 // Single cycle pulse
      case (state)
        S_IDLE: begin
          if (accept) begin
            tgt_q <= target;
            op_q  <= req_op;
            if (rom_rd) begin
              state   <= S_ROM_WAIT;
              sram_oe <= 1'b1;
              lat_cnt <= '0;
            end else begin
              state <= S_RESP;
            end
          end
        end
        S_ROM_WAIT: begin
          if (lat_last) begin
            sram_oe <= 1'b0;
            state   <= S_RESP;
          end else begin
            lat_cnt <= lat_cnt + 1'b1;
          end
        end
        S_RESP: begin
          rsp_valid <= 1'b1;
          state     <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Payload held until the next accept
  always_ff @(posedge CLK) begin
    if (accept) begin
      sram_addr <= rom_addr;
      data_q    <= acc_data;
    end else if ((state == S_ROM_WAIT) && lat_last && (op_q == OP_READ)) begin
      data_q <= sram_rdata;              // Last enabled cycle
    end
  end

  assign rsp_data   = data_q;
  assign rsp_target = tgt_q;

  ////////////////////////////////////////
  // Protocol checks
  ////////////////////////////////////////
  a_rsp_single: assert property (
    @(posedge CLK) disable iff (reset)
    rsp_valid |=> !rsp_valid
  );

  // SRAM enabled only while a ROM read waits
  a_oe_rom_wait: assert property (
    @(posedge CLK) disable iff (reset)
    sram_oe |-> (state == S_ROM_WAIT) && (tgt_q == TGT_ROM) && (op_q == OP_READ)
  );

endmodule

/* hw/cart_top.sv */
`timescale 1ns/10ps

module cart_top
  import cart_bus_pkg::*;
(
  input  logic        CLK,
  input  logic        reset,
  // Host request
  input  logic        req_valid,
  output logic        req_ready,
  input  bus_op_e     req_op,
  input  logic        req_pa_cycle,
  input  logic [23:0] req_addr,
  input  logic [7:0]  req_pa,
  input  logic        req_cs,
  input  logic [7:0]  req_wdata,
  // Static config
  input  logic [7:0]  featurebits,
  input  logic [23:0] rom_mask,
  // Host response
  output logic        rsp_valid,
  output logic [7:0]  rsp_data,
  output target_e     rsp_target,
  // SRAM
  output logic        sram_oe,
  output logic [23:0] sram_addr,
  input  logic [7:0]  sram_rdata
);

  target_e     target;
  logic [23:0] rom_addr;
  logic [3:0]  cmd_index;
  logic [7:0]  reg_rdata;
  logic        reg_wr_en;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////
  address u_address (
    .req_pa_cycle (req_pa_cycle),
    .req_addr     (req_addr),
    .req_pa       (req_pa),
    .req_cs       (req_cs),
    .featurebits  (featurebits),
    .rom_mask     (rom_mask),
    .target       (target),
    .rom_addr     (rom_addr),
    .cmd_index    (cmd_index)
  );

  ////////////////////////////////////////
  // Sequencer and registers
  ////////////////////////////////////////
  cart_seq u_seq (
    .CLK        (CLK),
    .reset      (reset),
    .req_valid  (req_valid),
    .req_op     (req_op),
    .target     (target),
    .rom_addr   (rom_addr),
    .sram_rdata (sram_rdata),
    .reg_rdata  (reg_rdata),
    .req_ready  (req_ready),
    .sram_oe    (sram_oe),
    .sram_addr  (sram_addr),
    .reg_wr_en  (reg_wr_en),
    .rsp_valid  (rsp_valid),
    .rsp_data   (rsp_data),
    .rsp_target (rsp_target)
  );

  // One index serves both ports since only one side is live per access
  snescmd_regs u_regs (
    .CLK       (CLK),
    .reset     (reset),
    .wr_en     (reg_wr_en),
    .wr_target (target),
    .wr_index  (cmd_index),
    .wr_data   (req_wdata),
    .rd_target (target),
    .rd_index  (cmd_index),
    .rd_data   (reg_rdata)
  );

endmodule

/* hw/snescmd_regs.sv */
`timescale 1ns/10ps

module snescmd_regs
  import cart_bus_pkg::*;
(
  input  logic       CLK,
  input  logic       reset,
  input  logic       wr_en,         // Pulse at the accept edge
  input  target_e    wr_target,
  input  logic [3:0] wr_index,
  input  logic [7:0] wr_data,
  input  target_e    rd_target,
  input  logic [3:0] rd_index,
  output logic [7:0] rd_data
);

  logic [7:0] cmd_buf [16];   // Command buffer
  logic [7:0] r213f_q;        // PA 3f latch

  ////////////////////////////////////////
  // Write side
  ////////////////////////////////////////
  // Buffer and latch read back as zero until written
  always_ff @(posedge CLK) begin
    if (reset) begin
      for (int i = 0; i < 16; i++) begin
        cmd_buf[i] <= 8'h00;
      end
      r213f_q <= 8'h00;
    end else if (wr_en) begin
      case (wr_target)
        TGT_CMD_WR: cmd_buf[wr_index] <= wr_data;
        TGT_213F:   r213f_q <= wr_data;
        default:    ;                        // Nothing stored
      endcase
    end
  end

  ////////////////////////////////////////
  // Read side
  ////////////////////////////////////////
  always_comb begin
    case (rd_target)
      TGT_CMD_RD: rd_data = cmd_buf[rd_index];
      TGT_213F:   rd_data = r213f_q;
      default:    rd_data = 8'h00;
    endcase
  end

  // The read-only PA window must never reach the write port
  a_no_cmd_rd_write: assert property (
    @(posedge CLK) disable iff (reset)
    wr_en |-> (wr_target != TGT_CMD_RD)
  );

endmodule

/* run.sh */
#!/bin/sh
# Builds the cart testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f src.f --top-module cart_tb \
  -Mdir obj_dir -o cart_sim \
  && ./obj_dir/cart_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "Test failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Test completed successfully" sim.log || { echo "No result in log"; exit 1; }
echo "PASS"
exit 0

/* src.f */
+incdir+hw
hw/cart_bus_pkg.sv
hw/cart_mem_pkg.sv
hw/address.sv
hw/snescmd_regs.sv
hw/cart_seq.sv
hw/cart_top.sv
dv/cart_checker.sv
dv/cart_tb.sv
